// ==== hw/mmx_data_pkg.sv ====
// Data types and saturation limits for packed MMX arithmetic, imported by datapath modules
package mmx_data_pkg;

	// --------------------
	// Widths
	// --------------------

	// Full MM register
	localparam int MM_REG_W = 64;

	// Packed word lane
	localparam int MM_WORD_W = 16;

	// Packed doubleword lane
	localparam int MM_DWORD_W = 32;

	// Number of 16-bit lanes in one register
	localparam int MM_LANES = MM_REG_W / MM_WORD_W;

	// --------------------
	// Saturation limits
	// --------------------

	// Signed word limits used by PADDSW
	localparam logic [MM_WORD_W-1:0] MM_WORD_MAX = 16'h7FFF;
	localparam logic [MM_WORD_W-1:0] MM_WORD_MIN = 16'h8000;

	// --------------------
	// Types
	// --------------------

	// One MM register value
	typedef logic [MM_REG_W-1:0] mm_reg_t;

	// One word lane
	typedef logic [MM_WORD_W-1:0] mm_word_t;

	// One doubleword lane
	typedef logic [MM_DWORD_W-1:0] mm_dword_t;

endpackage

// ==== hw/mmx_ctrl_pkg.sv ====
// Control definitions for the MMX slice: opcodes, register index and writeback sources
package mmx_ctrl_pkg;

	// --------------------
	// Register file
	// --------------------

	localparam int MM_NUM_REGS = 8;
	localparam int MM_IDX_W = $clog2(MM_NUM_REGS);

	// Register index
	typedef logic [MM_IDX_W-1:0] mm_idx_t;

	// --------------------
	// ALU operations
	// --------------------

	// Codes 6 and 7 are unused and give zero
	typedef enum logic [2:0] {
		OP_PADDW  = 3'd0,
		OP_PADDD  = 3'd1,
		OP_PADDSW = 3'd2,
		OP_PSHUFW = 3'd3,
		OP_PASS   = 3'd4,
		OP_SWAP   = 3'd5
	} mm_op_e;

	// --------------------
	// Writeback sources
	// --------------------

	// Last winner of the shared write port
	typedef enum logic {
		WB_ALU  = 1'b0,
		WB_LOAD = 1'b1
	} wb_src_e;

endpackage

// ==== hw/mmx_wb_if.sv ====
// Writeback request/grant bundle; one instance per writer, connected to the arbiter
interface mmx_wb_if
	import mmx_data_pkg::*, mmx_ctrl_pkg::*;
();

	// Writer wants the write port
	logic req;

	// Write happens at the edge where this is high
	logic grant;

	// Destination register and its value
	mm_idx_t idx;
	mm_reg_t data;

	// Pipe side
	modport writer (
		output req,
		output idx,
		output data,
		input grant
	);

	// Arbiter side
	modport arbiter (
		input req,
		input idx,
		input data,
		output grant
	);

endinterface

// ==== hw/mmx_alu.sv ====
// Combinational packed ALU; computes all six MMX operations and selects one by opcode
module mmx_alu
	import mmx_data_pkg::*, mmx_ctrl_pkg::*;
(
	input mm_reg_t a,
	input mm_reg_t b,
	input logic [7:0] imm,
	input mm_op_e op,
	output mm_reg_t result
);

	mm_reg_t paddw_res;
	mm_reg_t paddd_res;
	mm_reg_t paddsw_res;
	mm_reg_t pshufw_res;
	mm_word_t b_lane [MM_LANES];

	// --------------------
	// Wrapping adds
	// --------------------

	always_comb begin
		paddw_res = '0;
		for (int i = 0; i < MM_LANES; i++) begin
			paddw_res[i*MM_WORD_W +: MM_WORD_W] =
				a[i*MM_WORD_W +: MM_WORD_W] + b[i*MM_WORD_W +: MM_WORD_W];
		end
	end

	// Two dword lanes, carries stop at bit 31
	always_comb begin : paddd_lanes
		mm_dword_t lo;
		mm_dword_t hi;
		lo = a[MM_DWORD_W-1:0] + b[MM_DWORD_W-1:0];
		hi = a[MM_REG_W-1:MM_DWORD_W] + b[MM_REG_W-1:MM_DWORD_W];
		paddd_res = {hi, lo};
	end

	// --------------------
	// Saturating add
	// --------------------

	always_comb begin : paddsw_lanes
		mm_word_t wa;
		mm_word_t wb;
		mm_word_t sum;
		paddsw_res = '0;
		for (int i = 0; i < MM_LANES; i++) begin
			wa = a[i*MM_WORD_W +: MM_WORD_W];
			wb = b[i*MM_WORD_W +: MM_WORD_W];
			sum = wa + wb;
			// Overflow only when both signs agree and the sum flips
			if (!wa[MM_WORD_W-1] && !wb[MM_WORD_W-1] && sum[MM_WORD_W-1]) begin
				paddsw_res[i*MM_WORD_W +: MM_WORD_W] = MM_WORD_MAX;
			end else if (wa[MM_WORD_W-1] && wb[MM_WORD_W-1] && !sum[MM_WORD_W-1]) begin
				paddsw_res[i*MM_WORD_W +: MM_WORD_W] = MM_WORD_MIN;
			end else begin
				paddsw_res[i*MM_WORD_W +: MM_WORD_W] = sum;
			end
		end
	end

	// --------------------
	// Word shuffle
	// --------------------

	always_comb begin
		for (int i = 0; i < MM_LANES; i++) begin
			b_lane[i] = b[i*MM_WORD_W +: MM_WORD_W];
		end
	end

	// Output lane i picks source lane imm[2i+1:2i]
	always_comb begin
		pshufw_res = '0;
		for (int i = 0; i < MM_LANES; i++) begin
			pshufw_res[i*MM_WORD_W +: MM_WORD_W] = b_lane[imm[2*i +: 2]];
		end
	end

	// Result select
	always_comb begin
		case (op)
			OP_PADDW:  result = paddw_res;
			OP_PADDD:  result = paddd_res;
			OP_PADDSW: result = paddsw_res;
			OP_PSHUFW: result = pshufw_res;
			OP_PASS:   result = a;
			OP_SWAP:   result = b;
			default:   result = '0;
		endcase
	end

endmodule

// ==== hw/mmx_regfile.sv ====
// Eight 64-bit MM registers; one write port, three combinational read ports (A, B, store)
module mmx_regfile
	import mmx_data_pkg::*, mmx_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic we,
	input mm_idx_t widx,
	input mm_reg_t wdata,
	input mm_idx_t ridx_a,
	input mm_idx_t ridx_b,
	input mm_idx_t ridx_s,
	output mm_reg_t rdata_a,
	output mm_reg_t rdata_b,
	output mm_reg_t rdata_s
);

	mm_reg_t regs [MM_NUM_REGS];

	// --------------------
	// Write port
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < MM_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[widx] <= wdata;
		end
	end

	// --------------------
	// Read ports
	// --------------------

	// Old value is seen during the write cycle
	assign rdata_a = regs[ridx_a];
	assign rdata_b = regs[ridx_b];

	// Store port
	assign rdata_s = regs[ridx_s];

endmodule

// ==== hw/mmx_alu_pipe.sv ====
// ALU issue stage; captures one packed ALU result and holds it until the arbiter grants writeback
module mmx_alu_pipe
	import mmx_data_pkg::*, mmx_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic issue,
	input mm_op_e op,
	input logic [7:0] imm,
	input mm_idx_t dst,
	input mm_reg_t opnd_a,
	input mm_reg_t opnd_b,
	output logic busy,
	mmx_wb_if.writer wb
);

	mm_reg_t alu_result;
	logic accept;

	// Holding register
	logic hold_valid;
	mm_idx_t hold_idx;
	mm_reg_t hold_data;

	mmx_alu alu_i (
		.a(opnd_a),
		.b(opnd_b),
		.imm(imm),
		.op(op),
		.result(alu_result)
	);

	// Strobes while busy are dropped
	assign accept = issue && !hold_valid;

	// --------------------
	// Entry control
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			hold_valid <= 1'b0;
		end else if (accept) begin
			hold_valid <= 1'b1;
		end else if (wb.grant) begin
			hold_valid <= 1'b0;
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (accept) begin
			hold_idx <= dst;
			hold_data <= alu_result;
		end
	end

	assign busy = hold_valid;
	assign wb.req = hold_valid;
	assign wb.idx = hold_idx;
	assign wb.data = hold_data;

endmodule

// ==== hw/mmx_load_pipe.sv ====
// Load stage; formats MOVQ or MOVD data and holds it until the arbiter grants writeback
module mmx_load_pipe
	import mmx_data_pkg::*, mmx_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic valid,
	input logic wide,
	input mm_idx_t dst,
	input mm_reg_t data,
	output logic busy,
	mmx_wb_if.writer wb
);

	mm_dword_t low_dword;
	mm_reg_t formatted;
	logic accept;

	logic hold_valid;
	mm_idx_t hold_idx;
	mm_reg_t hold_data;

	// MOVQ keeps all 64 bits, MOVD zero-extends the low half
	assign low_dword = data[MM_DWORD_W-1:0];
	assign formatted = wide ? data : mm_reg_t'(low_dword);

	assign accept = valid && !hold_valid;

	// --------------------
	// Holding register
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			hold_valid <= 1'b0;
		end else if (accept) begin
			hold_valid <= 1'b1;
		end else if (wb.grant) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			hold_idx <= dst;
			hold_data <= formatted;
		end
	end

	assign busy = hold_valid;
	assign wb.req = hold_valid;
	assign wb.idx = hold_idx;
	assign wb.data = hold_data;

endmodule

// ==== hw/mmx_wb_arbiter.sv ====
// Round-robin arbiter between the ALU and load pipes for the single register-file write port
module mmx_wb_arbiter
	import mmx_data_pkg::*, mmx_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	mmx_wb_if.arbiter alu,
	mmx_wb_if.arbiter load,
	output logic we,
	output mm_idx_t widx,
	output mm_reg_t wdata
);

	wb_src_e last_winner;
	logic grant_alu;
	logic grant_load;

	// On a tie the writer that lost last time goes first
	always_comb begin
		grant_alu = 1'b0;
		grant_load = 1'b0;
		if (alu.req && load.req) begin
			if (last_winner == WB_ALU) begin
				grant_load = 1'b1;
			end else begin
				grant_alu = 1'b1;
			end
		end else begin
			grant_alu = alu.req;
			grant_load = load.req;
		end
	end

	// Only moves when someone actually wins
	always_ff @(posedge clk) begin
		if (reset) begin
			last_winner <= WB_LOAD;
		end else if (grant_alu) begin
			last_winner <= WB_ALU;
		end else if (grant_load) begin
			last_winner <= WB_LOAD;
		end
	end

	assign alu.grant = grant_alu;
	assign load.grant = grant_load;

	// Winner's payload to the write port
	assign we = grant_alu || grant_load;
	assign widx = grant_alu ? alu.idx : load.idx;
	assign wdata = grant_alu ? alu.data : load.data;

endmodule

// ==== hw/mmx_unit.sv ====
// Top of the MMX execution slice; connect issue, load and store ports to drive the unit
module mmx_unit
	import mmx_data_pkg::*, mmx_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,

	// ALU issue
	input logic alu_issue,
	input mm_op_e alu_op,
	input mm_idx_t alu_src_a,
	input mm_idx_t alu_src_b,
	input mm_idx_t alu_dst,
	input logic [7:0] alu_imm,
	output logic alu_busy,

	// Load
	input logic load_valid,
	input logic load_wide,
	input mm_idx_t load_dst,
	input mm_reg_t load_data,
	output logic load_busy,

	// Store
	input mm_idx_t store_idx,
	output mm_reg_t store_data
);

	mm_reg_t rdata_a;
	mm_reg_t rdata_b;
	logic rf_we;
	mm_idx_t rf_widx;
	mm_reg_t rf_wdata;

	mmx_wb_if wb_alu ();
	mmx_wb_if wb_load ();

	// --------------------
	// Writers
	// --------------------

	mmx_alu_pipe alu_pipe_i (
		.clk(clk),
		.reset(reset),
		.issue(alu_issue),
		.op(alu_op),
		.imm(alu_imm),
		.dst(alu_dst),
		.opnd_a(rdata_a),
		.opnd_b(rdata_b),
		.busy(alu_busy),
		.wb(wb_alu.writer)
	);

	mmx_load_pipe load_pipe_i (
		.clk(clk),
		.reset(reset),
		.valid(load_valid),
		.wide(load_wide),
		.dst(load_dst),
		.data(load_data),
		.busy(load_busy),
		.wb(wb_load.writer)
	);

	// --------------------
	// Write port and registers
	// --------------------

	mmx_wb_arbiter wb_arbiter_i (
		.clk(clk),
		.reset(reset),
		.alu(wb_alu.arbiter),
		.load(wb_load.arbiter),
		.we(rf_we),
		.widx(rf_widx),
		.wdata(rf_wdata)
	);

	mmx_regfile regfile_i (
		.clk(clk),
		.reset(reset),
		.we(rf_we),
		.widx(rf_widx),
		.wdata(rf_wdata),
		.ridx_a(alu_src_a),
		.ridx_b(alu_src_b),
		.ridx_s(store_idx),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.rdata_s(store_data)
	);

endmodule

// ==== tb/tb_mmx_unit.sv ====
// Directed testbench for mmx_unit; checks loads, ALU ops, contention and back-pressure vs a model
module tb_mmx_unit
	import mmx_data_pkg::*, mmx_ctrl_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	// About 300 operations at up to 4 cycles each, plus the register sweeps
	localparam int CYCLE_LIMIT = 4000;
	localparam int BUSY_LIMIT = 10;

	logic clk;
	logic reset;
	logic alu_issue;
	mm_op_e alu_op;
	mm_idx_t alu_src_a;
	mm_idx_t alu_src_b;
	mm_idx_t alu_dst;
	logic [7:0] alu_imm;
	logic alu_busy;
	logic load_valid;
	logic load_wide;
	mm_idx_t load_dst;
	mm_reg_t load_data;
	logic load_busy;
	mm_idx_t store_idx;
	mm_reg_t store_data;

	// Expected register contents
	mm_reg_t shadow [MM_NUM_REGS];
	int error_count = 0;
	int cycle_count = 0;

	mmx_unit mmx_unit_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// Run limit
	// --------------------

	always @(posedge clk) cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("Timeout: run stopped after %0d cycles before the tests finished", CYCLE_LIMIT);
		$display("ERRORS FOUND");
		$finish;
	end

	// --------------------
	// Reference model
	// --------------------

	function automatic mm_reg_t ref_alu(mm_op_e op, mm_reg_t a, mm_reg_t b, logic [7:0] imm);
		mm_reg_t r;
		int s;
		r = '0;
		case (op)
			OP_PADDW: begin
				for (int i = 0; i < MM_LANES; i++) begin
					r[16*i +: 16] = a[16*i +: 16] + b[16*i +: 16];
				end
			end
			OP_PADDD: begin
				r[31:0] = a[31:0] + b[31:0];
				r[63:32] = a[63:32] + b[63:32];
			end
			OP_PADDSW: begin
				// Signed sum in full width, then clamp
				for (int i = 0; i < MM_LANES; i++) begin
					s = int'($signed(a[16*i +: 16])) + int'($signed(b[16*i +: 16]));
					if (s > 32767) begin
						s = 32767;
					end else if (s < -32768) begin
						s = -32768;
					end
					r[16*i +: 16] = 16'(s);
				end
			end
			OP_PSHUFW: begin
				for (int i = 0; i < MM_LANES; i++) begin
					r[16*i +: 16] = b[16*int'(imm[2*i +: 2]) +: 16];
				end
			end
			OP_PASS: r = a;
			OP_SWAP: r = b;
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic mm_reg_t ref_load(logic wide, mm_reg_t data);
		return wide ? data : {32'h0, data[31:0]};
	endfunction

	// --------------------
	// Checks
	// --------------------

	task automatic check_reg(string what, mm_reg_t got, mm_reg_t exp);
		if (got !== exp) begin
			error_count++;
			$display("Fail %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_busy(string what, logic got, logic exp);
		if (got !== exp) begin
			error_count++;
			$display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// --------------------
	// Drivers
	// --------------------

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic set_alu(mm_op_e op, mm_idx_t a, mm_idx_t b, mm_idx_t dst, logic [7:0] imm);
		alu_issue = 1'b1;
		alu_op = op;
		alu_src_a = a;
		alu_src_b = b;
		alu_dst = dst;
		alu_imm = imm;
	endtask

	task automatic set_load(logic wide, mm_idx_t dst, mm_reg_t data);
		load_valid = 1'b1;
		load_wide = wide;
		load_dst = dst;
		load_data = data;
	endtask

	task automatic clear_strobes();
		alu_issue = 1'b0;
		load_valid = 1'b0;
	endtask

	// Both busy levels low, or give up after BUSY_LIMIT cycles
	task automatic wait_idle();
		int waited;
		waited = 0;
		while ((alu_busy || load_busy) && waited < BUSY_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (alu_busy || load_busy) begin
			error_count++;
			$display("Error at %0t: busy never cleared", $time);
		end
	endtask

	task automatic read_reg(mm_idx_t idx, output mm_reg_t val);
		next_cycle();
		store_idx = idx;
		#2;
		val = store_data;
	endtask

	task automatic check_all(string what);
		mm_reg_t got;
		for (int i = 0; i < MM_NUM_REGS; i++) begin
			read_reg(3'(i), got);
			check_reg($sformatf("%s r%0d", what, i), got, shadow[i]);
		end
	endtask

	task automatic run_alu(mm_op_e op, mm_idx_t a, mm_idx_t b, mm_idx_t dst, logic [7:0] imm);
		mm_reg_t exp;
		mm_reg_t got;
		exp = ref_alu(op, shadow[a], shadow[b], imm);
		next_cycle();
		set_alu(op, a, b, dst, imm);
		next_cycle();
		clear_strobes();
		wait_idle();
		shadow[dst] = exp;
		read_reg(dst, got);
		check_reg($sformatf("op %0d into r%0d", op, dst), got, exp);
	endtask

	task automatic run_load(logic wide, mm_idx_t dst, mm_reg_t data);
		mm_reg_t got;
		next_cycle();
		set_load(wide, dst, data);
		next_cycle();
		clear_strobes();
		wait_idle();
		shadow[dst] = ref_load(wide, data);
		read_reg(dst, got);
		check_reg(wide ? "MOVQ" : "MOVD", got, shadow[dst]);
	endtask

	// ALU issue and load in one cycle; alu_first says which write lands first
	task automatic contend(mm_idx_t alu_dst_idx, mm_idx_t load_dst_idx, logic alu_first);
		mm_reg_t data;
		mm_reg_t exp_alu;
		data = {$urandom, $urandom};
		exp_alu = ref_alu(OP_PADDW, shadow[1], shadow[2], 8'h00);
		next_cycle();
		set_alu(OP_PADDW, 3'd1, 3'd2, alu_dst_idx, 8'h00);
		set_load(1'b1, load_dst_idx, data);
		next_cycle();
		clear_strobes();
		check_busy("alu_busy under contention", alu_busy, 1'b1);
		check_busy("load_busy under contention", load_busy, 1'b1);
		// One grant per cycle, the writer that lost last time goes first
		next_cycle();
		check_busy("alu_busy after first grant", alu_busy, !alu_first);
		check_busy("load_busy after first grant", load_busy, alu_first);
		wait_idle();
		shadow[alu_dst_idx] = exp_alu;
		shadow[load_dst_idx] = data;
	endtask

	// --------------------
	// Tests
	// --------------------

	task automatic test_reset();
		check_busy("alu_busy after reset", alu_busy, 1'b0);
		check_busy("load_busy after reset", load_busy, 1'b0);
		check_all("reset");
	endtask

	task automatic test_loads();
		run_load(1'b1, 3'd0, {$urandom, $urandom});
		run_load(1'b1, 3'd1, {$urandom, $urandom});
		// Upper half set so the zero-extension shows
		run_load(1'b0, 3'd2, {32'hdead_beef, $urandom});
		// Saturation corners for PADDSW
		run_load(1'b1, 3'd3, 64'h7fff_8000_7fff_0001);
		run_load(1'b1, 3'd4, 64'h0001_ffff_7fff_8000);
		run_load(1'b1, 3'd5, 64'h8000_8000_0000_7fff);
	endtask

	task automatic test_alu_ops();
		mm_op_e op;
		for (int code = 0; code < 8; code++) begin
			op = mm_op_e'(3'(code));
			run_alu(op, 3'd1, 3'd2, 3'd6, 8'($urandom));
			run_alu(op, 3'd3, 3'd4, 3'd7, 8'($urandom));
			run_alu(op, 3'd3, 3'd5, 3'd6, 8'($urandom));
			run_alu(op, 3'd0, 3'd1, 3'd7, 8'h1b);
		end
	endtask

	task automatic test_contention();
		// Last lone write from the ALU pipe
		run_alu(OP_PASS, 3'd0, 3'd0, 3'd0, 8'h00);
		contend(3'd6, 3'd7, 1'b0);
		// Last lone write from the load pipe
		run_load(1'b1, 3'd5, 64'h8000_8000_0000_7fff);
		contend(3'd7, 3'd6, 1'b1);
		check_all("contention");
	endtask

	task automatic test_backpressure();
		mm_reg_t exp;
		exp = ref_alu(OP_PASS, shadow[1], shadow[1], 8'h00);
		next_cycle();
		set_alu(OP_PASS, 3'd1, 3'd1, 3'd6, 8'h00);
		next_cycle();
		check_busy("alu_busy after issue", alu_busy, 1'b1);
		// Second strobe lands while busy and must be dropped
		set_alu(OP_SWAP, 3'd2, 3'd2, 3'd5, 8'h00);
		next_cycle();
		clear_strobes();
		wait_idle();
		shadow[6] = exp;
		check_all("back-pressure");
	endtask

	task automatic test_random();
		int kind;
		mm_op_e op;
		mm_idx_t src_a;
		mm_idx_t src_b;
		mm_idx_t dst_a;
		mm_idx_t dst_l;
		logic [7:0] imm;
		logic wide;
		mm_reg_t data;
		mm_reg_t exp_alu;
		for (int n = 0; n < 200; n++) begin
			// 0 load only, 1 ALU only, 2 both in the same cycle
			kind = int'($urandom_range(2, 0));
			op = mm_op_e'(3'($urandom));
			src_a = 3'($urandom);
			src_b = 3'($urandom);
			dst_a = 3'($urandom);
			dst_l = 3'($urandom);
			if (kind == 2 && dst_l == dst_a) begin
				dst_l = dst_a + 3'd1;
			end
			imm = 8'($urandom);
			wide = 1'($urandom);
			data = {$urandom, $urandom};
			exp_alu = ref_alu(op, shadow[src_a], shadow[src_b], imm);
			next_cycle();
			if (kind != 0) begin
				set_alu(op, src_a, src_b, dst_a, imm);
			end
			if (kind != 1) begin
				set_load(wide, dst_l, data);
			end
			next_cycle();
			clear_strobes();
			wait_idle();
			if (kind != 0) begin
				shadow[dst_a] = exp_alu;
			end
			if (kind != 1) begin
				shadow[dst_l] = ref_load(wide, data);
			end
		end
		check_all("random");
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial begin
		void'($urandom(32'h0b36_9801));
		reset = 1'b1;
		alu_issue = 1'b0;
		alu_op = OP_PADDW;
		alu_src_a = '0;
		alu_src_b = '0;
		alu_dst = '0;
		alu_imm = '0;
		load_valid = 1'b0;
		load_wide = 1'b0;
		load_dst = '0;
		load_data = '0;
		store_idx = '0;
		for (int i = 0; i < MM_NUM_REGS; i++) begin
			shadow[i] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		test_reset();
		test_loads();
		test_alu_ops();
		test_contention();
		test_backpressure();
		test_random();

		$display("Run complete with %0d errors", error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== files.f ====
hw/mmx_data_pkg.sv
hw/mmx_ctrl_pkg.sv
hw/mmx_wb_if.sv
hw/mmx_alu.sv
hw/mmx_regfile.sv
hw/mmx_alu_pipe.sv
hw/mmx_load_pipe.sv
hw/mmx_wb_arbiter.sv
hw/mmx_unit.sv
tb/tb_mmx_unit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_mmx_unit
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "test passed" || (echo "test failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
